/* hdl/sram_pkg.sv */
`default_nettype none

package sram_pkg;

	// One memory word. The CPU data path and both SRAM data buses carry this width.
	typedef logic [31:0] data_t;

	// Word address as issued by the memory stage. The top bit picks the chip.
	typedef logic [20:0] addr_t;

	// Word address inside a single SRAM chip.
	typedef logic [19:0] bank_addr_t;

	// Address bit that selects the ext chip (1) over the base chip (0).
	localparam int BANK_SEL_BIT = 20;

	// Depth of one chip as a power of two, used by the behavioral model.
	localparam int SRAM_WORDS_LOG2 = 20;

	// Sequencer states for one bank.
	// IDLE keeps every strobe high.
	// STROBE holds the chip enabled for the access time.
	// RECOVER releases the strobes and presents the result for one cycle.
	typedef enum logic [1:0] {
		IDLE,
		STROBE,
		RECOVER
	} bank_state_e;

endpackage

`default_nettype wire

/* hdl/sram_bank_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// Strobe sequencer for one asynchronous SRAM chip.
// A start pulse loads the address and write word, then the chip is held
// enabled for access_cycles clocks, followed by one recovery cycle with done.
module sram_bank_ctrl #(
	parameter int access_cycles = 2
) (
	input  wire                        clk,
	input  wire                        rst_n,

	input  wire                        start,
	input  wire                        write,
	input  wire sram_pkg::bank_addr_t  bank_addr,
	input  wire sram_pkg::data_t       wdata,
	output logic                       done,
	output sram_pkg::data_t            rdata,

	output sram_pkg::bank_addr_t       ram_addr,
	inout  wire sram_pkg::data_t       ram_data,
	output logic                       ram_ce_n,
	output logic                       ram_oe_n,
	output logic                       ram_we_n
);

	// The counter runs from access_cycles-1 down to zero inside STROBE.
	localparam int cnt_w = (access_cycles > 1) ? $clog2(access_cycles) : 1;
	localparam logic [cnt_w-1:0] cnt_load = cnt_w'(access_cycles - 1);

	sram_pkg::bank_state_e state;
	sram_pkg::bank_state_e state_next;

	logic [cnt_w-1:0] cnt;
	logic             write_q;
	logic             launch;
	logic             strobe_last;
	sram_pkg::data_t  wdata_q;

	if (access_cycles < 1) begin : g_bad_access_cycles
		$error("sram_bank_ctrl: access_cycles must be at least 1");
	end

	assign launch      = (state == sram_pkg::IDLE) && start;
	assign strobe_last = (state == sram_pkg::STROBE) && (cnt == '0);

	// The result is presented for exactly the one RECOVER cycle.
	assign done = (state == sram_pkg::RECOVER);

	// The chip only sees our data while the write strobe is asserted.
	// Outside of it the bus floats so a read can be driven by the SRAM.
	assign ram_data = ram_we_n ? 'z : wdata_q;

	always_comb begin
		state_next = state;
		unique case (state)
			sram_pkg::IDLE: begin
				if (start) begin
					state_next = sram_pkg::STROBE;
				end
			end
			sram_pkg::STROBE: begin
				if (cnt == '0) begin
					state_next = sram_pkg::RECOVER;
				end
			end
			sram_pkg::RECOVER: begin
				state_next = sram_pkg::IDLE;
			end
			default: begin
				state_next = sram_pkg::IDLE;
			end
		endcase
	end

	// Strobes are registered so the pins never glitch on decode.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= sram_pkg::IDLE;
			cnt      <= '0;
			write_q  <= 1'b0;
			ram_ce_n <= 1'b1;
			ram_oe_n <= 1'b1;
			ram_we_n <= 1'b1;
		end else begin
			state <= state_next;
			if (launch) begin
				cnt      <= cnt_load;
				write_q  <= write;
				ram_ce_n <= 1'b0;
				ram_oe_n <= write;
				ram_we_n <= !write;
			end else if (state == sram_pkg::STROBE) begin
				if (cnt == '0) begin
					// End of the access window. Everything goes back high together.
					ram_ce_n <= 1'b1;
					ram_oe_n <= 1'b1;
					ram_we_n <= 1'b1;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

	// Address and data latches. Their contents only matter while the
	// strobes qualify them.
	always_ff @(posedge clk) begin
		if (launch) begin
			ram_addr <= bank_addr;
			wdata_q  <= wdata;
		end
		if (strobe_last && !write_q) begin
			rdata <= ram_data;
		end
	end

	// A read and a write strobe together would fight the SRAM on the data bus.
	a_oe_we_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n)
		ram_oe_n || ram_we_n
	) else $error("sram_bank_ctrl: oe_n and we_n low together");

	// The top level must wait for done before starting this bank again.
	a_start_only_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		start |-> (state == sram_pkg::IDLE)
	) else $error("sram_bank_ctrl: start while sequencer is busy");

endmodule

`default_nettype wire

/* hdl/ram_driver.sv */
`timescale 1ns/1ps
`default_nettype none

// Memory-stage front end for the base and ext SRAM chips.
// One request is accepted at a time. The top address bit is latched with the
// request, and only that bank's sequencer is started and listened to.
module ram_driver #(
	parameter int access_cycles = 2
) (
	input  wire                        clk,
	input  wire                        rst_n,

	input  wire                        enable,
	input  wire                        read_enable,
	input  wire                        write_enable,
	input  wire sram_pkg::addr_t       addr,
	input  wire sram_pkg::data_t       data_in,
	output sram_pkg::data_t            data_out,
	output logic                       ack,

	output sram_pkg::bank_addr_t       baseram_addr,
	inout  wire sram_pkg::data_t       baseram_data,
	output logic                       baseram_ce_n,
	output logic                       baseram_oe_n,
	output logic                       baseram_we_n,

	output sram_pkg::bank_addr_t       extram_addr,
	inout  wire sram_pkg::data_t       extram_data,
	output logic                       extram_ce_n,
	output logic                       extram_oe_n,
	output logic                       extram_we_n
);

	logic                 busy;
	logic                 bank_q;
	logic                 bank_sel;
	logic                 req_rw;
	logic                 accept;
	logic                 write;
	logic                 start_base;
	logic                 start_ext;
	logic                 base_done;
	logic                 ext_done;
	logic                 sel_done;
	sram_pkg::bank_addr_t bank_addr;
	sram_pkg::data_t      base_rdata;
	sram_pkg::data_t      ext_rdata;
	sram_pkg::data_t      sel_rdata;

	// Address split, done once for both banks.
	assign bank_sel  = addr[sram_pkg::BANK_SEL_BIT];
	assign bank_addr = addr[sram_pkg::BANK_SEL_BIT-1:0];

	// The ack cycle is excluded so that a held enable with stale request
	// values is not taken a second time.
	assign req_rw = read_enable || write_enable;
	assign accept = enable && !busy && !ack;

	// Read wins when both enables are set.
	assign write = !read_enable;

	assign start_base = accept && req_rw && !bank_sel;
	assign start_ext  = accept && req_rw && bank_sel;

	// Only the latched bank can finish the outstanding request.
	assign sel_done  = bank_q ? ext_done : base_done;
	assign sel_rdata = bank_q ? ext_rdata : base_rdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			bank_q <= 1'b0;
			ack    <= 1'b0;
		end else begin
			ack <= 1'b0;
			if (accept) begin
				if (req_rw) begin
					busy   <= 1'b1;
					bank_q <= bank_sel;
				end else begin
					// No-op request, answered straight away.
					ack <= 1'b1;
				end
			end
			if (busy && sel_done) begin
				busy <= 1'b0;
				ack  <= 1'b1;
			end
		end
	end

	// Read data is registered in the same edge as ack.
	always_ff @(posedge clk) begin
		if (busy && sel_done) begin
			data_out <= sel_rdata;
		end
	end

	sram_bank_ctrl #(
		.access_cycles(access_cycles)
	) base_ctrl_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start_base),
		.write    (write),
		.bank_addr(bank_addr),
		.wdata    (data_in),
		.done     (base_done),
		.rdata    (base_rdata),
		.ram_addr (baseram_addr),
		.ram_data (baseram_data),
		.ram_ce_n (baseram_ce_n),
		.ram_oe_n (baseram_oe_n),
		.ram_we_n (baseram_we_n)
	);

	sram_bank_ctrl #(
		.access_cycles(access_cycles)
	) ext_ctrl_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start_ext),
		.write    (write),
		.bank_addr(bank_addr),
		.wdata    (data_in),
		.done     (ext_done),
		.rdata    (ext_rdata),
		.ram_addr (extram_addr),
		.ram_data (extram_data),
		.ram_ce_n (extram_ce_n),
		.ram_oe_n (extram_oe_n),
		.ram_we_n (extram_we_n)
	);

	// The requester needs one idle cycle after ack to change its request.
	a_ack_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		ack |=> !ack
	) else $error("ram_driver: ack high on consecutive cycles");

	// Both chips share the request lines, so only one may be enabled at a time.
	a_one_chip: assert property (
		@(posedge clk) disable iff (!rst_n)
		baseram_ce_n || extram_ce_n
	) else $error("ram_driver: both chips enabled together");

endmodule

`default_nettype wire

/* verif/sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

// Behavioral asynchronous SRAM. A read is combinational while ce_n and oe_n
// are low. A write is committed when we_n rises at the end of the pulse.
module sram_model (
	input  wire sram_pkg::bank_addr_t addr,
	inout  wire sram_pkg::data_t      data,
	input  wire                       ce_n,
	input  wire                       oe_n,
	input  wire                       we_n
);

	sram_pkg::data_t      mem [0:(2**sram_pkg::SRAM_WORDS_LOG2)-1];
	sram_pkg::bank_addr_t wr_addr;
	sram_pkg::data_t      wr_data;

	assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

	// Address and data are tracked for as long as the write pulse lasts.
	always_latch begin
		if (!ce_n && !we_n) begin
			wr_addr <= addr;
			wr_data <= data;
		end
	end

	// Like a real part, the word is taken on the trailing edge of we_n.
	always @(posedge we_n) begin
		mem[wr_addr] <= wr_data;
	end

endmodule

`default_nettype wire

/* verif/tb_ram_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ram_driver;

	localparam int access_cycles  = 2;
	localparam int req_latency    = access_cycles + 2;
	// Reset, 70 read or write requests of req_latency+1 cycles, two no-ops of
	// two cycles and one idle cycle after four tests, with 20 percent margin.
	localparam int timeout_cycles = (12 + 70 * (req_latency + 1) + 2 * 2 + 4) * 6 / 5;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 enable;
	logic                 read_enable;
	logic                 write_enable;
	sram_pkg::addr_t      addr;
	sram_pkg::data_t      data_in;
	sram_pkg::data_t      data_out;
	logic                 ack;
	sram_pkg::bank_addr_t base_addr;
	wire sram_pkg::data_t base_data;
	logic                 base_ce_n;
	logic                 base_oe_n;
	logic                 base_we_n;
	sram_pkg::bank_addr_t ext_addr;
	wire sram_pkg::data_t ext_data;
	logic                 ext_ce_n;
	logic                 ext_oe_n;
	logic                 ext_we_n;

	logic [31:0] lcg_state;
	int          cycle_count = 0;
	int          error_count = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	ram_driver #(
		.access_cycles(access_cycles)
	) ram_driver_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.enable      (enable),
		.read_enable (read_enable),
		.write_enable(write_enable),
		.addr        (addr),
		.data_in     (data_in),
		.data_out    (data_out),
		.ack         (ack),
		.baseram_addr(base_addr),
		.baseram_data(base_data),
		.baseram_ce_n(base_ce_n),
		.baseram_oe_n(base_oe_n),
		.baseram_we_n(base_we_n),
		.extram_addr (ext_addr),
		.extram_data (ext_data),
		.extram_ce_n (ext_ce_n),
		.extram_oe_n (ext_oe_n),
		.extram_we_n (ext_we_n)
	);

	sram_model base_sram_i (
		.addr(base_addr),
		.data(base_data),
		.ce_n(base_ce_n),
		.oe_n(base_oe_n),
		.we_n(base_we_n)
	);

	sram_model ext_sram_i (
		.addr(ext_addr),
		.data(ext_data),
		.ce_n(ext_ce_n),
		.oe_n(ext_oe_n),
		.we_n(ext_we_n)
	);

	// A floating bus reads as all ones.
	pullup base_pull_i (base_data);
	pullup ext_pull_i (ext_data);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic sram_pkg::addr_t make_addr(input logic bank,
			input sram_pkg::bank_addr_t low);
		sram_pkg::addr_t a;
		a = '0;
		a[sram_pkg::BANK_SEL_BIT-1:0] = low;
		a[sram_pkg::BANK_SEL_BIT] = bank;
		return a;
	endfunction

	task automatic check_data(input string name, input sram_pkg::data_t actual,
			input sram_pkg::data_t expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s got %08h expected %08h", $time, name, actual,
				expected);
			error_count++;
		end
	endtask

	task automatic check_addr(input string name, input sram_pkg::bank_addr_t actual,
			input sram_pkg::bank_addr_t expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s got %05h expected %05h", $time, name, actual,
				expected);
			error_count++;
		end
	endtask

	task automatic check_latency(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, actual,
				expected);
			error_count++;
		end
	endtask

	task automatic check_strobes(input string name, input logic [2:0] actual,
			input logic [2:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s got %03b expected %03b", $time, name, actual,
				expected);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, actual,
				expected);
			error_count++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d check(s) failed", name, error_count - errors_before);
		end
	endtask

	task automatic drive_idle();
		enable       <= 1'b0;
		read_enable  <= 1'b0;
		write_enable <= 1'b0;
		@(posedge clk);
	endtask

	// Issues one request and waits for its ack. The bank that was not
	// addressed must keep its strobes high the whole time, and the addressed
	// bank must present the word address while its chip is enabled.
	task automatic do_request(input logic rd, input logic wr, input sram_pkg::addr_t a,
			input sram_pkg::data_t d, output sram_pkg::data_t rdata, output int latency);
		logic noop;
		logic ack_seen;
		int   cycles;
		noop = !rd && !wr;
		enable       <= 1'b1;
		read_enable  <= rd;
		write_enable <= wr;
		addr         <= a;
		data_in      <= d;
		@(posedge clk);
		cycles = 0;
		ack_seen = 1'b0;
		while (!ack_seen) begin
			@(posedge clk);
			cycles++;
			if (noop || a[sram_pkg::BANK_SEL_BIT]) begin
				check_strobes("baseram strobes", {base_ce_n, base_oe_n, base_we_n}, 3'b111);
			end else if (!base_ce_n) begin
				check_addr("baseram_addr", base_addr, a[sram_pkg::BANK_SEL_BIT-1:0]);
			end
			if (noop || !a[sram_pkg::BANK_SEL_BIT]) begin
				check_strobes("extram strobes", {ext_ce_n, ext_oe_n, ext_we_n}, 3'b111);
			end else if (!ext_ce_n) begin
				check_addr("extram_addr", ext_addr, a[sram_pkg::BANK_SEL_BIT-1:0]);
			end
			ack_seen = (ack === 1'b1);
		end
		rdata = data_out;
		latency = cycles;
	endtask

	task automatic write_word(input sram_pkg::addr_t a, input sram_pkg::data_t d);
		sram_pkg::data_t unused_rdata;
		int              latency;
		do_request(1'b0, 1'b1, a, d, unused_rdata, latency);
		check_latency("write ack latency", latency, req_latency);
	endtask

	task automatic read_word(input sram_pkg::addr_t a, input sram_pkg::data_t expected);
		sram_pkg::data_t rdata;
		int              latency;
		do_request(1'b1, 1'b0, a, '0, rdata, latency);
		check_latency("read ack latency", latency, req_latency);
		check_data("data_out", rdata, expected);
	endtask

	task automatic check_idle_pins();
		check_strobes("baseram strobes", {base_ce_n, base_oe_n, base_we_n}, 3'b111);
		check_strobes("extram strobes", {ext_ce_n, ext_oe_n, ext_we_n}, 3'b111);
		check_flag("ack", ack, 1'b0);
		check_data("baseram_data", base_data, '1);
		check_data("extram_data", ext_data, '1);
	endtask

	task automatic test_reset();
		int errors_before;
		errors_before = error_count;
		repeat (5) @(posedge clk);
		check_idle_pins();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		check_idle_pins();
		finish_test("reset state", errors_before);
	endtask

	task automatic test_base_round_trip();
		int              errors_before;
		logic [31:0]     r;
		sram_pkg::addr_t a;
		sram_pkg::data_t d;
		errors_before = error_count;
		r = lcg_word();
		a = make_addr(1'b0, r[19:0]);
		d = lcg_word();
		write_word(a, d);
		read_word(a, d);
		drive_idle();
		finish_test("base bank round trip", errors_before);
	endtask

	task automatic test_ext_isolation();
		int              errors_before;
		logic [31:0]     r;
		sram_pkg::data_t d_base;
		sram_pkg::data_t d_ext;
		errors_before = error_count;
		r = lcg_word();
		d_base = lcg_word();
		d_ext = ~d_base;
		write_word(make_addr(1'b0, r[19:0]), d_base);
		write_word(make_addr(1'b1, r[19:0]), d_ext);
		read_word(make_addr(1'b0, r[19:0]), d_base);
		read_word(make_addr(1'b1, r[19:0]), d_ext);
		drive_idle();
		finish_test("ext bank round trip and isolation", errors_before);
	endtask

	task automatic test_back_to_back();
		int              errors_before;
		int              i;
		logic [31:0]     r;
		sram_pkg::addr_t a;
		sram_pkg::data_t d;
		sram_pkg::addr_t order [$];
		sram_pkg::data_t scoreboard [sram_pkg::addr_t];
		errors_before = error_count;
		for (i = 0; i < 32; i++) begin
			r = lcg_word();
			a = make_addr(i[0], r[19:0]);
			d = lcg_word();
			scoreboard[a] = d;
			order.push_back(a);
			write_word(a, d);
		end
		for (i = 0; i < 32; i++) begin
			read_word(order[i], scoreboard[order[i]]);
		end
		drive_idle();
		finish_test("held enable and back-to-back requests", errors_before);
	endtask

	task automatic test_noop();
		int              errors_before;
		int              latency;
		logic [31:0]     r;
		sram_pkg::data_t rdata;
		errors_before = error_count;
		r = lcg_word();
		do_request(1'b0, 1'b0, make_addr(1'b0, r[19:0]), r, rdata, latency);
		check_latency("no-op ack latency", latency, 1);
		do_request(1'b0, 1'b0, make_addr(1'b1, r[19:0]), r, rdata, latency);
		check_latency("no-op ack latency", latency, 1);
		drive_idle();
		finish_test("no-op request", errors_before);
	endtask

	initial begin
		lcg_state    = 32'hacf2_aa9b;
		rst_n        = 1'b0;
		enable       = 1'b0;
		read_enable  = 1'b0;
		write_enable = 1'b0;
		addr         = '0;
		data_in      = '0;
		test_reset();
		test_base_round_trip();
		test_ext_isolation();
		test_back_to_back();
		test_noop();
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hdl/sram_pkg.sv
hdl/sram_bank_ctrl.sv
hdl/ram_driver.sv
verif/sram_model.sv
verif/tb_ram_driver.sv

/* Makefile */
# Verilator build and run for the SRAM controller testbench.

VERILATOR ?= verilator
TOP       ?= tb_ram_driver
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the testbench prints its pass line.
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)
